/* fb_pkg.sv */
package fb_pkg;

	// Memory and pixel widths
	localparam int ADDR_WIDTH = 8;
	localparam int PIX_WIDTH = 16;

	// Two readers plus one writer plus one spare for the last done frame
	localparam int BUF_NUM = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [PIX_WIDTH-1:0] pix_t;

	// One-hot buffer ownership, zero means nothing held
	typedef logic [BUF_NUM-1:0] buf_bmp_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_CLAIM,
		RD_STREAM
	} rd_state_t;

endpackage

/* filelist.f */
fb_pkg.sv
mutex_buffer_ctl.sv
frame_writer.sv
frame_reader.sv
frame_mem.sv
frame_buffer_top.sv
frame_buffer_checker.sv
tb_clock.sv
tb_frame_buffer.sv

/* frame_buffer_checker.sv */
`timescale 1ns/1ps

module frame_buffer_checker
	import fb_pkg::*;
(
	input logic     clk,
	input logic     resetn,
	input logic     w_sof,
	input buf_bmp_t w_bmp,
	input buf_bmp_t r0_bmp,
	input buf_bmp_t r1_bmp
);

	// Writer owns a buffer once the first frame has started
	logic started;

	// Number of failed assertions so far
	int fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			started <= 1'b0;
		end else if (w_sof) begin
			started <= 1'b1;
		end
	end

	a_w_onehot: assert property (@(posedge clk) disable iff (!resetn)
		started |-> $onehot(w_bmp))
		else begin
			fail_cnt++;
			$error("writer bitmap is not one-hot");
		end

	// Writer never targets a buffer that a reader holds
	a_w_disjoint: assert property (@(posedge clk) disable iff (!resetn)
		(w_bmp & (r0_bmp | r1_bmp)) == '0)
		else begin
			fail_cnt++;
			$error("writer bitmap overlaps a reader bitmap");
		end

	a_r0_onehot0: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(r0_bmp))
		else begin
			fail_cnt++;
			$error("reader 0 bitmap holds more than one buffer");
		end

	a_r1_onehot0: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(r1_bmp))
		else begin
			fail_cnt++;
			$error("reader 1 bitmap holds more than one buffer");
		end

endmodule

bind mutex_buffer_ctl frame_buffer_checker i_checker (
	.clk    (clk),
	.resetn (resetn),
	.w_sof  (w_sof),
	.w_bmp  (w_bmp),
	.r0_bmp (r0_bmp),
	.r1_bmp (r1_bmp)
);

/* frame_buffer_top.sv */
`timescale 1ns/1ps

module frame_buffer_top
	import fb_pkg::*;
#(
	parameter int FRAME_WORDS = 16
) (
	input  logic  clk,
	input  logic  resetn,

	input  addr_t buf0_addr,
	input  addr_t buf1_addr,
	input  addr_t buf2_addr,
	input  addr_t buf3_addr,

	input  logic  in_valid,
	input  logic  in_sof,
	input  pix_t  in_data,

	input  logic  rd0_sof,
	output logic  out0_valid,
	output pix_t  out0_data,
	output logic  out0_last,

	input  logic  rd1_sof,
	output logic  out1_valid,
	output pix_t  out1_data,
	output logic  out1_last
);

	// Controller handshakes
	logic  w_sof;
	addr_t w_addr;
	logic  r0_sof;
	addr_t r0_addr;
	logic  r1_sof;
	addr_t r1_addr;

	// Memory ports
	logic  mem_we;
	addr_t mem_waddr;
	pix_t  mem_wdata;
	addr_t raddr0;
	addr_t raddr1;
	pix_t  rdata0;
	pix_t  rdata1;

	mutex_buffer_ctl i_buffer_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.buf0_addr (buf0_addr),
		.buf1_addr (buf1_addr),
		.buf2_addr (buf2_addr),
		.buf3_addr (buf3_addr),
		.w_sof     (w_sof),
		.w_addr    (w_addr),
		.r0_sof    (r0_sof),
		.r0_addr   (r0_addr),
		.r1_sof    (r1_sof),
		.r1_addr   (r1_addr)
	);

	frame_writer #(
		.FRAME_WORDS (FRAME_WORDS)
	) i_writer (
		.clk       (clk),
		.resetn    (resetn),
		.in_valid  (in_valid),
		.in_sof    (in_sof),
		.in_data   (in_data),
		.w_sof     (w_sof),
		.w_addr    (w_addr),
		.mem_we    (mem_we),
		.mem_waddr (mem_waddr),
		.mem_wdata (mem_wdata)
	);

	frame_reader #(
		.FRAME_WORDS (FRAME_WORDS)
	) i_reader0 (
		.clk       (clk),
		.resetn    (resetn),
		.rd_sof    (rd0_sof),
		.r_sof     (r0_sof),
		.r_addr    (r0_addr),
		.mem_raddr (raddr0),
		.mem_rdata (rdata0),
		.out_valid (out0_valid),
		.out_data  (out0_data),
		.out_last  (out0_last)
	);

	frame_reader #(
		.FRAME_WORDS (FRAME_WORDS)
	) i_reader1 (
		.clk       (clk),
		.resetn    (resetn),
		.rd_sof    (rd1_sof),
		.r_sof     (r1_sof),
		.r_addr    (r1_addr),
		.mem_raddr (raddr1),
		.mem_rdata (rdata1),
		.out_valid (out1_valid),
		.out_data  (out1_data),
		.out_last  (out1_last)
	);

	frame_mem i_mem (
		.clk    (clk),
		.we     (mem_we),
		.waddr  (mem_waddr),
		.wdata  (mem_wdata),
		.raddr0 (raddr0),
		.raddr1 (raddr1),
		.rdata0 (rdata0),
		.rdata1 (rdata1)
	);

endmodule

/* frame_mem.sv */
`timescale 1ns/1ps

module frame_mem
	import fb_pkg::*;
(
	input  logic  clk,

	input  logic  we,
	input  addr_t waddr,
	input  pix_t  wdata,

	input  addr_t raddr0,
	input  addr_t raddr1,
	output pix_t  rdata0,
	output pix_t  rdata1
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	pix_t mem [DEPTH];

	// Single write port, shared by the writer
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge clk) begin
		rdata0 <= mem[raddr0];
		rdata1 <= mem[raddr1];
	end

endmodule

/* frame_reader.sv */
`timescale 1ns/1ps

module frame_reader
	import fb_pkg::*;
#(
	parameter int FRAME_WORDS = 16
) (
	input  logic  clk,
	input  logic  resetn,

	input  logic  rd_sof,
	output logic  r_sof,
	input  addr_t r_addr,

	output addr_t mem_raddr,
	input  pix_t  mem_rdata,

	output logic  out_valid,
	output pix_t  out_data,
	output logic  out_last
);

	localparam int CNT_W = $clog2(FRAME_WORDS + 1);

	rd_state_t        state;
	logic [CNT_W-1:0] word_cnt;
	addr_t            base_q;

	// Read issue for the current cycle
	addr_t cur_base;
	logic  issue;
	logic  issue_last;

	// Claim goes straight to the controller
	assign r_sof = rd_sof;

	// A strobe in progress cancels the read of the old frame
	assign issue      = (state != RD_IDLE) && !rd_sof;
	assign issue_last = issue && (word_cnt == CNT_W'(FRAME_WORDS - 1));

	// Claimed address is only on r_addr in the claim cycle
	assign cur_base  = (state == RD_CLAIM) ? r_addr : base_q;
	assign mem_raddr = cur_base + addr_t'(word_cnt);

	//////////////////////////////////////////////////////////////////////
	// Reader FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= RD_IDLE;
			word_cnt <= '0;
			base_q   <= '0;
		end else if (rd_sof) begin
			// Restart, also when a frame is still streaming
			state    <= RD_CLAIM;
			word_cnt <= '0;
		end else if (issue) begin
			if (state == RD_CLAIM) begin
				base_q <= r_addr;
			end
			if (issue_last) begin
				state    <= RD_IDLE;
				word_cnt <= '0;
			end else begin
				state    <= RD_STREAM;
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output stream
	//////////////////////////////////////////////////////////////////////

	// Memory read takes one cycle, flags follow the issue by one
	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= issue;
			out_last  <= issue_last;
		end
	end

	assign out_data = mem_rdata;

endmodule

/* frame_writer.sv */
`timescale 1ns/1ps

module frame_writer
	import fb_pkg::*;
#(
	parameter int FRAME_WORDS = 16
) (
	input  logic  clk,
	input  logic  resetn,

	input  logic  in_valid,
	input  logic  in_sof,
	input  pix_t  in_data,

	output logic  w_sof,
	input  addr_t w_addr,

	output logic  mem_we,
	output addr_t mem_waddr,
	output pix_t  mem_wdata
);

	localparam int CNT_W = $clog2(FRAME_WORDS + 1);

	// Offset the next pixel would take, saturates at FRAME_WORDS
	logic [CNT_W-1:0] wr_cnt;
	logic [CNT_W-1:0] pix_off;

	// One stage of delay so w_addr has switched before the first write
	logic [CNT_W-1:0] off_q;
	logic             we_q;
	pix_t             pix_q;

	// Controller sees the frame start in the same cycle
	assign w_sof = in_valid & in_sof;

	assign pix_off = in_sof ? '0 : wr_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// Drop everything until the first frame start
			wr_cnt <= CNT_W'(FRAME_WORDS);
			off_q  <= '0;
			we_q   <= 1'b0;
		end else begin
			we_q <= in_valid && (pix_off < FRAME_WORDS);
			if (in_valid) begin
				off_q <= pix_off;
			end
			if (in_valid && (pix_off < FRAME_WORDS)) begin
				wr_cnt <= pix_off + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			pix_q <= in_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory write port
	//////////////////////////////////////////////////////////////////////

	assign mem_we    = we_q;
	assign mem_waddr = w_addr + addr_t'(off_q);
	assign mem_wdata = pix_q;

endmodule

/* mutex_buffer_ctl.sv */
`timescale 1ns/1ps

module mutex_buffer_ctl
	import fb_pkg::*;
(
	input  logic  clk,
	input  logic  resetn,

	input  addr_t buf0_addr,
	input  addr_t buf1_addr,
	input  addr_t buf2_addr,
	input  addr_t buf3_addr,

	input  logic  w_sof,
	output addr_t w_addr,

	input  logic  r0_sof,
	output addr_t r0_addr,

	input  logic  r1_sof,
	output addr_t r1_addr
);

	// Ownership bitmaps
	buf_bmp_t w_bmp;
	buf_bmp_t r0_bmp;
	buf_bmp_t r1_bmp;
	buf_bmp_t last_bmp;
	addr_t    last_addr;

	// Writer target selection
	buf_bmp_t busy_bmp;
	buf_bmp_t free_bmp;
	addr_t    free_addr;

	// What a reader strobing now would receive
	buf_bmp_t claim_bmp;
	addr_t    claim_addr;

	//////////////////////////////////////////////////////////////////////
	// Free buffer search
	//////////////////////////////////////////////////////////////////////

	// Lowest buffer not held by the writer or either reader
	always_comb begin
		busy_bmp = w_bmp | r0_bmp | r1_bmp;
		casez (busy_bmp)
			4'b???0: begin
				free_addr = buf0_addr;
				free_bmp  = 4'b0001;
			end
			4'b??01: begin
				free_addr = buf1_addr;
				free_bmp  = 4'b0010;
			end
			4'b?011: begin
				free_addr = buf2_addr;
				free_bmp  = 4'b0100;
			end
			4'b0111: begin
				free_addr = buf3_addr;
				free_bmp  = 4'b1000;
			end
			default: begin
				// Cannot happen with three owners and four buffers
				free_addr = '0;
				free_bmp  = '0;
			end
		endcase
	end

	// A frame finishing this very cycle beats the older last frame
	assign claim_addr = w_sof ? w_addr : last_addr;
	assign claim_bmp  = w_sof ? w_bmp : last_bmp;

	//////////////////////////////////////////////////////////////////////
	// Writer and last completed frame
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			w_addr    <= '0;
			w_bmp     <= '0;
			last_addr <= '0;
			last_bmp  <= '0;
		end else if (w_sof) begin
			last_addr <= w_addr;
			last_bmp  <= w_bmp;
			w_addr    <= free_addr;
			w_bmp     <= free_bmp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			r0_addr <= '0;
			r0_bmp  <= '0;
		end else if (r0_sof) begin
			r0_addr <= claim_addr;
			r0_bmp  <= claim_bmp;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			r1_addr <= '0;
			r1_bmp  <= '0;
		end else if (r1_sof) begin
			r1_addr <= claim_addr;
			r1_bmp  <= claim_bmp;
		end
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

/* tb_frame_buffer.sv */
`timescale 1ns/1ps

module tb_frame_buffer;
	import fb_pkg::*;

	localparam int FRAME_WORDS = 16;
	localparam int TIMEOUT = 60;

	logic clk;
	logic resetn;
	logic in_valid;
	logic in_sof;
	pix_t in_data;
	logic rd0_sof;
	logic rd1_sof;
	logic out0_valid;
	logic out0_last;
	pix_t out0_data;
	logic out1_valid;
	logic out1_last;
	pix_t out1_data;

	int    cyc = 0;
	int    errors = 0;
	string test_name = "reset";

	// Writer model and record of completed frames
	int wr_frame;
	int wr_idx;
	int last_done;

	// Expected frames per reader, small ring of strobes
	int exp_frame [2][8];
	int exp_cyc [2][8];
	int exp_wr [2];
	int exp_rd [2];
	int busy_until [2];

	tb_clock i_clock (.clk(clk));

	frame_buffer_top #(
		.FRAME_WORDS (FRAME_WORDS)
	) i_frame_buffer_top (
		.clk        (clk),
		.resetn     (resetn),
		.buf0_addr  (8'd0),
		.buf1_addr  (8'd32),
		.buf2_addr  (8'd64),
		.buf3_addr  (8'd96),
		.in_valid   (in_valid),
		.in_sof     (in_sof),
		.in_data    (in_data),
		.rd0_sof    (rd0_sof),
		.out0_valid (out0_valid),
		.out0_data  (out0_data),
		.out0_last  (out0_last),
		.rd1_sof    (rd1_sof),
		.out1_valid (out1_valid),
		.out1_data  (out1_data),
		.out1_last  (out1_last)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Frame handed to a reader strobed now
	function automatic int ref_frame(input bit sof_now, input int cur, input int last);
		return sof_now ? cur : last;
	endfunction

	// Frame number in the upper byte, pixel index in the lower
	function automatic pix_t ref_pixel(input int frame, input int idx);
		return {frame[7:0], idx[7:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic push_expect(input int rd, input int frame);
		exp_frame[rd][exp_wr[rd] % 8] = frame;
		exp_cyc[rd][exp_wr[rd] % 8] = cyc;
		exp_wr[rd]++;
		busy_until[rd] = cyc + FRAME_WORDS + 4;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// One clock of inputs; cut forces an early start of frame
	task automatic run_cycle(input bit pix_en, input bit cut, input bit s0, input bit s1);
		bit new_frame;
		@(posedge clk);
		#1;
		new_frame = pix_en && (cut || wr_idx >= FRAME_WORDS);
		// Readers see the record before this start of frame lands
		if (s0) begin
			push_expect(0, ref_frame(new_frame, wr_frame, last_done));
		end
		if (s1) begin
			push_expect(1, ref_frame(new_frame, wr_frame, last_done));
		end
		if (new_frame) begin
			last_done = wr_frame;
			wr_frame++;
			wr_idx = 0;
		end
		in_valid = pix_en;
		in_sof   = new_frame;
		in_data  = ref_pixel(wr_frame, wr_idx);
		rd0_sof  = s0;
		rd1_sof  = s1;
		if (pix_en) begin
			wr_idx++;
		end
	endtask

	task automatic run_random(input int cycles);
		bit s0;
		bit s1;
		repeat (cycles) begin
			s0 = (last_done >= 0) && (cyc > busy_until[0]) && ($urandom % 12 == 0);
			s1 = (last_done >= 0) && (cyc > busy_until[1]) && ($urandom % 12 == 0);
			run_cycle($urandom % 4 != 0, 1'b0, s0, s1);
		end
	endtask

	// Idle the inputs until every expected reader frame is out
	task automatic drain();
		int waited;
		waited = 0;
		while ((exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]) && waited < 4 * TIMEOUT) begin
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
			waited++;
		end
		if (exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]) begin
			errors++;
			$display("reader frames did not finish in time during %s", test_name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare
	//////////////////////////////////////////////////////////////////////

	task automatic compare_stream(input int rd);
		int    idx;
		int    waited;
		int    slot;
		string tag;
		logic  valid;
		logic  last;
		pix_t  data;
		idx = 0;
		waited = 0;
		forever begin
			@(negedge clk);
			valid = rd ? out1_valid : out0_valid;
			last  = rd ? out1_last : out0_last;
			data  = rd ? out1_data : out0_data;
			slot  = exp_rd[rd] % 8;
			tag   = $sformatf("%s r%0d", test_name, rd);
			if (valid && exp_rd[rd] == exp_wr[rd]) begin
				errors++;
				$display("reader %0d sent a pixel without a strobe", rd);
			end else if (valid) begin
				waited = 0;
				if (idx == 0) begin
					check({tag, " latency"}, exp_cyc[rd][slot] + 2, cyc);
				end
				check({tag, " pixel"}, ref_pixel(exp_frame[rd][slot], idx), data);
				check({tag, " last"}, idx == FRAME_WORDS - 1, last);
				idx++;
				if (last || idx == FRAME_WORDS) begin
					exp_rd[rd]++;
					idx = 0;
				end
			end else begin
				// Gap inside a frame, only a pending restart strobe may cut it
				if (idx > 0) begin
					if (exp_wr[rd] - exp_rd[rd] < 2) begin
						errors++;
						$display("%s frame ended after %0d pixels", tag, idx);
					end
					exp_rd[rd]++;
					idx = 0;
				end
				waited = (exp_rd[rd] != exp_wr[rd]) ? waited + 1 : 0;
				if (waited > TIMEOUT) begin
					errors++;
					$display("reader %0d timed out waiting for out_valid", rd);
					exp_rd[rd]++;
					waited = 0;
				end
			end
		end
	endtask

	initial begin
		int i;
		int asrt_fails;
		void'($urandom(54202));
		resetn   = 1'b0;
		in_valid = 1'b0;
		in_sof   = 1'b0;
		in_data  = '0;
		rd0_sof  = 1'b0;
		rd1_sof  = 1'b0;
		wr_frame  = -1;
		wr_idx    = FRAME_WORDS;
		last_done = -1;
		for (i = 0; i < 2; i++) begin
			exp_wr[i] = 0;
			exp_rd[i] = 0;
			busy_until[i] = 0;
		end
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		fork
			compare_stream(0);
			compare_stream(1);
		join_none

		test_name = "single_read";
		repeat (2 * FRAME_WORDS + 1) run_cycle(1'b1, 1'b0, 1'b0, 1'b0);
		run_cycle(1'b0, 1'b0, 1'b1, 1'b0);
		drain();

		test_name = "two_readers";
		for (i = 0; i < 3 * FRAME_WORDS; i++) begin
			run_cycle(1'b1, 1'b0, i == 3 || i == 30, i == 10 || i == 40);
		end
		drain();

		// Strobe lands together with the next start of frame
		test_name = "sof_handover";
		while (wr_idx < FRAME_WORDS) begin
			run_cycle(1'b1, 1'b0, 1'b0, 1'b0);
		end
		run_cycle(1'b1, 1'b0, 1'b1, 1'b1);
		drain();

		// Short frames rush through the free buffers while reader 0 holds one
		test_name = "held_buffer";
		run_cycle(1'b1, 1'b0, 1'b1, 1'b0);
		for (i = 0; i < FRAME_WORDS; i++) begin
			run_cycle(1'b1, i % 4 == 3, 1'b0, 1'b0);
		end
		drain();
		repeat (3 * FRAME_WORDS) run_cycle(1'b1, 1'b0, 1'b0, 1'b0);

		test_name = "restart";
		for (i = 0; i < 2 * FRAME_WORDS; i++) begin
			run_cycle(1'b1, 1'b0, 1'b0, i == 0 || i == 8);
		end
		drain();

		test_name = "random";
		run_random(1500);
		drain();

		asrt_fails = i_frame_buffer_top.i_buffer_ctl.i_checker.fail_cnt;
		$display("errors: %0d, assertion failures: %0d", errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
